//--- Makefile
SIM  := obj_dir/Vtb_vpu_pipe
SRCS := $(filter-out +%,$(shell cat vpu_pipe.f)) rtl/vpu_config.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): vpu_pipe.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ns -f vpu_pipe.f --top-module tb_vpu_pipe

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

//--- rtl/vpu_config.svh
`ifndef VPU_CONFIG_SVH
`define VPU_CONFIG_SVH

//////////////////////////////////////////////////
// VPU geometry
//////////////////////////////////////////////////

// Lanes per vector register
`define VPU_LANES 8

// Width of one lane, also the scalar width
`define VPU_LANE_W 16

// Vector registers in the file, indexed by 3 bits
`define VPU_NREGS 8

//////////////////////////////////////////////////
// Execute timing
//////////////////////////////////////////////////

// Execute cycles for VMUL, at least 2
`define VPU_MUL_CYCLES 2

`endif

//--- rtl/vpu_lane_alu.sv
`timescale 1ns/1ns
`include "vpu_config.svh"

module vpu_lane_alu (
    input  logic                 clk,
    input  logic                 rst_n,
    // Writeback back-pressure, freezes sequencing
    input  logic                 hold,
    // Operand register side
    input  logic                 op_valid,
    input  vpu_pkg::op_bundle_t  op,
    // Multiply still in progress
    output logic                 busy,
    // Result register side
    output logic                 res_valid,
    output vpu_pkg::res_bundle_t res
);

    //////////////////////////////////////////////////
    // Multiply sequencing
    //////////////////////////////////////////////////

    localparam int CNT_W = $clog2(`VPU_MUL_CYCLES);
    localparam logic [CNT_W-1:0] MUL_LAST = CNT_W'(`VPU_MUL_CYCLES - 1);

    // Execute cycle of the current VMUL
    logic [CNT_W-1:0] mul_cnt;
    // Products captured in the first cycle
    vpu_pkg::vec_t    mul_q;
    logic             is_mul;

    assign is_mul = op_valid && (op.op == vpu_pkg::VMUL);

    // Busy until the last multiply cycle
    assign busy = is_mul && (mul_cnt != MUL_LAST);

    // Advance only while writeback moves
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mul_cnt <= '0;
        end else if (!hold) begin
            if (busy) begin
                mul_cnt <= mul_cnt + 1'b1;
            end else begin
                // Back to zero once the result leaves
                mul_cnt <= '0;
            end
        end
    end

    // Lane products, low 16 bits kept
    always_ff @(posedge clk) begin
        if (busy && (mul_cnt == '0)) begin
            for (int i = 0; i < `VPU_LANES; i++) begin
                mul_q[i] <= vpu_pkg::lane_t'(op.a[i] * op.b[i]);
            end
        end
    end

    //////////////////////////////////////////////////
    // Lane arithmetic
    //////////////////////////////////////////////////

    vpu_pkg::vec_t  lane_res;
    vpu_pkg::lane_t rsum;

    // Per-lane ops, wraps at 16 bits
    always_comb begin
        lane_res = '0;
        for (int i = 0; i < `VPU_LANES; i++) begin
            case (op.op)
                vpu_pkg::VADD, vpu_pkg::VADDS: lane_res[i] = op.a[i] + op.b[i];
                vpu_pkg::VSUB:                 lane_res[i] = op.a[i] - op.b[i];
                vpu_pkg::VMAX: begin
                    // Signed compare
                    if ($signed(op.a[i]) > $signed(op.b[i])) begin
                        lane_res[i] = op.a[i];
                    end else begin
                        lane_res[i] = op.b[i];
                    end
                end
                vpu_pkg::VSPLAT:               lane_res[i] = op.b[i];
                vpu_pkg::VMUL:                 lane_res[i] = mul_q[i];
                default:                       lane_res[i] = '0;
            endcase
        end
    end

    // Reduction over operand a, modulo 2^16
    always_comb begin
        rsum = '0;
        for (int i = 0; i < `VPU_LANES; i++) begin
            rsum = rsum + op.a[i];
        end
    end

    //////////////////////////////////////////////////
    // Result bundle
    //////////////////////////////////////////////////

    // Valid held back while the multiply runs
    assign res_valid = op_valid && !busy;

    always_comb begin
        res    = '0;
        res.vd = op.vd;
        // VRSUM leaves the register file alone
        res.we = (op.op != vpu_pkg::VRSUM);
        res.v  = lane_res;
        res.ro = (op.op == vpu_pkg::VRSUM) ? rsum : '0;
    end

endmodule

//--- rtl/vpu_operand_stage.sv
`timescale 1ns/1ns
`include "vpu_config.svh"

module vpu_operand_stage (
    // Issued instruction fields
    input  vpu_pkg::vop_e       issue_op,
    input  vpu_pkg::reg_idx_t   issue_vd,
    input  vpu_pkg::reg_idx_t   issue_va,
    input  vpu_pkg::reg_idx_t   issue_vb,
    input  vpu_pkg::lane_t      issue_scalar,
    // Register file read side
    output vpu_pkg::reg_idx_t   ra_idx,
    output vpu_pkg::reg_idx_t   rb_idx,
    input  vpu_pkg::vec_t       ra_data,
    input  vpu_pkg::vec_t       rb_data,
    // Operand bundle toward the operand register
    output vpu_pkg::op_bundle_t bundle
);

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    // Scalar replicated over all lanes
    vpu_pkg::vec_t splat;
    // Operand b comes from the scalar
    logic          use_scalar;
    // Selected operand b
    vpu_pkg::vec_t b_sel;

    // Read addresses straight from the issue fields
    assign ra_idx = issue_va;
    assign rb_idx = issue_vb;

    // Broadcast
    assign splat = {`VPU_LANES{issue_scalar}};

    // Scalar-form ops ignore vb
    assign use_scalar = (issue_op == vpu_pkg::VADDS) || (issue_op == vpu_pkg::VSPLAT);

    assign b_sel = use_scalar ? splat : rb_data;

    //////////////////////////////////////////////////
    // Bundle
    //////////////////////////////////////////////////

    // Pack for the operand register, valid added by the top
    always_comb begin
        bundle        = '0;
        bundle.op     = issue_op;
        bundle.vd     = issue_vd;
        bundle.a      = ra_data;
        bundle.b      = b_sel;
        // Kept for debug visibility downstream
        bundle.scalar = issue_scalar;
    end

endmodule

//--- rtl/vpu_pipe.sv
`timescale 1ns/1ns

module vpu_pipe (
    input  logic              clk,
    input  logic              rst_n,
    // Issue side
    input  logic              issue_valid,
    input  vpu_pkg::vop_e     issue_op,
    input  vpu_pkg::reg_idx_t issue_vd,
    input  vpu_pkg::reg_idx_t issue_va,
    input  vpu_pkg::reg_idx_t issue_vb,
    input  vpu_pkg::lane_t    issue_scalar,
    output logic              issue_ready,
    // Writeback side
    output logic              wb_valid,
    output vpu_pkg::reg_idx_t wb_vd,
    output logic              wb_we,
    output vpu_pkg::vec_t     wb_vec,
    output vpu_pkg::lane_t    wb_scalar,
    input  logic              wb_ready
);

    //////////////////////////////////////////////////
    // Interconnect
    //////////////////////////////////////////////////

    // Register file reads
    vpu_pkg::reg_idx_t    ra_idx;
    vpu_pkg::reg_idx_t    rb_idx;
    vpu_pkg::vec_t        ra_data;
    vpu_pkg::vec_t        rb_data;
    // Operand stage to operand register
    vpu_pkg::op_bundle_t  op_bundle;
    // Operand register to ALU
    logic                 op_valid;
    vpu_pkg::op_bundle_t  op_q;
    // ALU to result register
    logic                 alu_busy;
    logic                 alu_valid;
    vpu_pkg::res_bundle_t alu_res;
    // Result register
    vpu_pkg::res_bundle_t res_q;
    // Stall terms
    logic                 hold_wb;
    logic                 stall_op;
    logic                 rf_we;

    // Sink back-pressure freezes the result register
    assign hold_wb = !wb_ready;

    // Operand register waits on multiply or on writeback
    assign stall_op    = alu_busy || hold_wb;
    assign issue_ready = !stall_op;

    // Register file written on the writeback handshake
    assign rf_we = wb_valid && wb_ready && res_q.we;

    //////////////////////////////////////////////////
    // Stages
    //////////////////////////////////////////////////

    vpu_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .ra_idx  (ra_idx),
        .ra_data (ra_data),
        .rb_idx  (rb_idx),
        .rb_data (rb_data),
        .we      (rf_we),
        .w_idx   (res_q.vd),
        .w_data  (res_q.v)
    );

    vpu_operand_stage u_operand (
        .issue_op     (issue_op),
        .issue_vd     (issue_vd),
        .issue_va     (issue_va),
        .issue_vb     (issue_vb),
        .issue_scalar (issue_scalar),
        .ra_idx       (ra_idx),
        .rb_idx       (rb_idx),
        .ra_data      (ra_data),
        .rb_data      (rb_data),
        .bundle       (op_bundle)
    );

    // Operand register, issue_valid qualifies the bundle
    vpu_pipe_reg #(.payload_t(vpu_pkg::op_bundle_t)) u_op_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall_op),
        .valid_in  (issue_valid),
        .data_in   (op_bundle),
        .valid_out (op_valid),
        .data_out  (op_q)
    );

    vpu_lane_alu u_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .hold      (hold_wb),
        .op_valid  (op_valid),
        .op        (op_q),
        .busy      (alu_busy),
        .res_valid (alu_valid),
        .res       (alu_res)
    );

    // Result register drives writeback directly
    vpu_pipe_reg #(.payload_t(vpu_pkg::res_bundle_t)) u_res_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (hold_wb),
        .valid_in  (alu_valid),
        .data_in   (alu_res),
        .valid_out (wb_valid),
        .data_out  (res_q)
    );

    //////////////////////////////////////////////////
    // Writeback outputs
    //////////////////////////////////////////////////

    assign wb_vd     = res_q.vd;
    assign wb_we     = res_q.we;
    assign wb_vec    = res_q.v;
    assign wb_scalar = res_q.ro;

endmodule

//--- rtl/vpu_pipe_reg.sv
`timescale 1ns/1ns

module vpu_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    // Hold current contents
    input  logic     stall,
    // Upstream side
    input  logic     valid_in,
    input  payload_t data_in,
    // Downstream side
    output logic     valid_out,
    output payload_t data_out
);

    //////////////////////////////////////////////////
    // Valid bit
    //////////////////////////////////////////////////

    // Clears on reset, loads when not stalled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else if (!stall) begin
            valid_out <= valid_in;
        end
    end

    //////////////////////////////////////////////////
    // Payload
    //////////////////////////////////////////////////

    // Same load and hold rule as the valid bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_out <= '0;
        end else if (!stall) begin
            data_out <= data_in;
        end
    end

endmodule

//--- rtl/vpu_pkg.sv
`include "vpu_config.svh"

package vpu_pkg;

    //////////////////////////////////////////////////
    // Basic data types
    //////////////////////////////////////////////////

    // One lane word
    typedef logic [`VPU_LANE_W-1:0] lane_t;

    // Full vector, lane 0 in the low bits
    typedef lane_t [`VPU_LANES-1:0] vec_t;

    // Register index
    typedef logic [$clog2(`VPU_NREGS)-1:0] reg_idx_t;

    // Opcodes
    typedef enum logic [2:0] {
        VADD   = 3'd0,
        VSUB   = 3'd1,
        VMUL   = 3'd2,
        VMAX   = 3'd3,
        VADDS  = 3'd4,
        VSPLAT = 3'd5,
        VRSUM  = 3'd6
    } vop_e;

    //////////////////////////////////////////////////
    // Stage payloads
    //////////////////////////////////////////////////

    // Operand stage to ALU, b already broadcast for scalar ops
    typedef struct packed {
        vop_e     op;
        reg_idx_t vd;
        vec_t     a;
        vec_t     b;
        lane_t    scalar;
    } op_bundle_t;

    // ALU to writeback
    typedef struct packed {
        reg_idx_t vd;
        logic     we;     // low for VRSUM
        vec_t     v;
        lane_t    ro;     // reduction result
    } res_bundle_t;

endpackage

//--- rtl/vpu_regfile.sv
`timescale 1ns/1ns
`include "vpu_config.svh"

module vpu_regfile (
    input  logic              clk,
    input  logic              rst_n,
    // Read port A
    input  vpu_pkg::reg_idx_t ra_idx,
    output vpu_pkg::vec_t     ra_data,
    // Read port B
    input  vpu_pkg::reg_idx_t rb_idx,
    output vpu_pkg::vec_t     rb_data,
    // Write port
    input  logic              we,
    input  vpu_pkg::reg_idx_t w_idx,
    input  vpu_pkg::vec_t     w_data
);

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    // Eight vectors of eight lanes
    vpu_pkg::vec_t regs [`VPU_NREGS];

    // Cleared on reset, written at the edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `VPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[w_idx] <= w_data;
        end
    end

    //////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////

    // Write-through, same-cycle write wins
    assign ra_data = (we && (w_idx == ra_idx)) ? w_data : regs[ra_idx];

    // Same bypass for port B
    assign rb_data = (we && (w_idx == rb_idx)) ? w_data : regs[rb_idx];

endmodule

//--- testbench/tb_vpu_pipe.sv
`timescale 1ns/1ns
`include "vpu_config.svh"

module tb_vpu_pipe;

    localparam int CLK_PERIOD   = 4;
    localparam int N_ARITH      = 150;
    localparam int N_STALL      = 200;
    // Splats, arithmetic, two timed ops, VRSUM pairs, stall stream
    localparam int N_TOTAL      = `VPU_NREGS + N_ARITH + 2 + 2 * `VPU_NREGS + N_STALL;
    // Cycles allowed for the few results still in flight to retire
    localparam int DRAIN_CYCLES = 100;

    logic              clk;
    logic              rst_n;
    logic              issue_valid;
    vpu_pkg::vop_e     issue_op;
    vpu_pkg::reg_idx_t issue_vd;
    vpu_pkg::reg_idx_t issue_va;
    vpu_pkg::reg_idx_t issue_vb;
    vpu_pkg::lane_t    issue_scalar;
    logic              issue_ready;
    logic              wb_valid;
    vpu_pkg::reg_idx_t wb_vd;
    logic              wb_we;
    vpu_pkg::vec_t     wb_vec;
    vpu_pkg::lane_t    wb_scalar;
    logic              wb_ready;

    // Expected results in issue order
    vpu_pkg::res_bundle_t exp_q [$];
    // Register model updated only at writeback
    vpu_pkg::vec_t        model [`VPU_NREGS];
    // A destination is pending while these two counts differ
    int                   issued_cnt [`VPU_NREGS];
    int                   done_cnt [`VPU_NREGS];
    logic [31:0]          rng;
    // Random wb_ready when set
    logic                 rand_ready;

    vpu_pipe uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_vd     (issue_vd),
        .issue_va     (issue_va),
        .issue_vb     (issue_vb),
        .issue_scalar (issue_scalar),
        .issue_ready  (issue_ready),
        .wb_valid     (wb_valid),
        .wb_vd        (wb_vd),
        .wb_we        (wb_we),
        .wb_vec       (wb_vec),
        .wb_scalar    (wb_scalar),
        .wb_ready     (wb_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Expected writeback for one instruction
    function automatic vpu_pkg::res_bundle_t vpu_ref(
        input vpu_pkg::vop_e op, input vpu_pkg::reg_idx_t vd,
        input vpu_pkg::vec_t a, input vpu_pkg::vec_t b, input vpu_pkg::lane_t scalar);
        vpu_pkg::res_bundle_t r;
        vpu_pkg::lane_t       bl;
        logic [31:0]          prod;
        int                   i;
        r    = '0;
        r.vd = vd;
        r.we = (op != vpu_pkg::VRSUM);
        for (i = 0; i < `VPU_LANES; i++) begin
            // Scalar forms take the scalar in every lane
            bl = (op == vpu_pkg::VADDS || op == vpu_pkg::VSPLAT) ? scalar : b[i];
            case (op)
                vpu_pkg::VADD, vpu_pkg::VADDS: r.v[i] = a[i] + bl;
                vpu_pkg::VSUB:                 r.v[i] = a[i] - bl;
                vpu_pkg::VMUL: begin
                    prod    = 32'(a[i]) * 32'(bl);
                    r.v[i] = prod[15:0];
                end
                vpu_pkg::VMAX:   r.v[i] = ($signed(a[i]) >= $signed(bl)) ? a[i] : bl;
                vpu_pkg::VSPLAT: r.v[i] = bl;
                default:         r.v[i] = '0;
            endcase
            // Lane sum wraps at 16 bits
            if (op == vpu_pkg::VRSUM) begin
                r.ro = r.ro + a[i];
            end
        end
        return r;
    endfunction

    function automatic logic is_pending(input vpu_pkg::reg_idx_t r);
        return issued_cnt[r] != done_cnt[r];
    endfunction

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic stop_on_error();
        $display("** FAIL **");
        $fatal(1, "stopped at %0t", $time);
    endtask

    task automatic check_vec(input string name, input vpu_pkg::vec_t got,
                             input vpu_pkg::vec_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_lane(input string name, input vpu_pkg::lane_t got,
                              input vpu_pkg::lane_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_idx(input string name, input vpu_pkg::reg_idx_t got,
                             input vpu_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    // Starts and ends on a falling edge
    task automatic issue_one(input vpu_pkg::vop_e op, input vpu_pkg::reg_idx_t vd,
                             input vpu_pkg::reg_idx_t va, input vpu_pkg::reg_idx_t vb,
                             input vpu_pkg::lane_t scalar);
        vpu_pkg::res_bundle_t exp;
        exp          = vpu_ref(op, vd, model[va], model[vb], scalar);
        issue_valid  = 1'b1;
        issue_op     = op;
        issue_vd     = vd;
        issue_va     = va;
        issue_vb     = vb;
        issue_scalar = scalar;
        // Ready is settled one ns after the falling edge
        #1;
        while (!issue_ready) begin
            @(negedge clk);
            #1;
        end
        exp_q.push_back(exp);
        if (exp.we) begin
            issued_cnt[vd] = issued_cnt[vd] + 1;
        end
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    // Only picks sources with no write in flight
    task automatic issue_random(input logic all_ops);
        vpu_pkg::vop_e     op;
        vpu_pkg::reg_idx_t va;
        vpu_pkg::reg_idx_t vb;
        rng = xorshift32(rng);
        if (all_ops) begin
            op = vpu_pkg::vop_e'(3'(rng % 32'd7));
        end else begin
            case (rng[1:0])
                2'd0:    op = vpu_pkg::VADD;
                2'd1:    op = vpu_pkg::VSUB;
                2'd2:    op = vpu_pkg::VMAX;
                default: op = vpu_pkg::VADDS;
            endcase
        end
        do begin
            rng = xorshift32(rng);
            va  = rng[2:0];
            vb  = rng[5:3];
        end while (is_pending(va) || is_pending(vb));
        issue_one(op, rng[8:6], va, vb, rng[31:16]);
    endtask

    // Latency counted from the accepting edge to wb_valid
    task automatic timed_op(input vpu_pkg::vop_e op, input int exp_edges);
        int edges;
        issue_one(op, 3'd1, 3'd2, 3'd3, 16'h0);
        edges = 1;
        #1;
        while (!wb_valid) begin
            // Extra multiply cycle blocks issue
            if (op == vpu_pkg::VMUL && edges == 1) begin
                check_bit("issue_ready", issue_ready, 1'b0);
            end
            if (edges > 8) begin
                $display("No writeback for %s after %0d edges", op.name(), edges);
                stop_on_error();
            end
            @(negedge clk);
            #1;
            edges++;
        end
        if (edges != exp_edges) begin
            $display("%s wrote back %0d edges after acceptance instead of %0d",
                     op.name(), edges, exp_edges);
            stop_on_error();
        end
        @(negedge clk);
    endtask

    // Gives outstanding results a bounded time to retire
    task automatic drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < DRAIN_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
    endtask

    // Switched on a rising edge to stay clear of the ready driver
    task automatic set_ready_mode(input logic mode);
        @(posedge clk);
        rand_ready = mode;
        @(negedge clk);
    endtask

    //////////////////////////////////////////////////
    // Processes
    //////////////////////////////////////////////////

    // Sink back-pressure
    initial begin : ready_driver
        logic [31:0] ready_rng;
        ready_rng = xorshift32(32'he8dc);
        wb_ready  = 1'b1;
        forever begin
            @(negedge clk);
            if (rand_ready) begin
                ready_rng = xorshift32(ready_rng);
                wb_ready  = ready_rng[7];
            end else begin
                wb_ready = 1'b1;
            end
        end
    end

    // Scoreboard samples ahead of each rising edge
    initial begin : compare
        logic                 held;
        vpu_pkg::res_bundle_t last;
        vpu_pkg::res_bundle_t exp;
        held = 1'b0;
        last = '0;
        for (int r = 0; r < `VPU_NREGS; r++) begin
            model[r]    = '0;
            done_cnt[r] = 0;
        end
        forever begin
            @(negedge clk);
            #1;
            if (rst_n) begin
                // Stalled writeback must not move
                if (held) begin
                    check_bit("wb_valid", wb_valid, 1'b1);
                    check_idx("wb_vd", wb_vd, last.vd);
                    check_bit("wb_we", wb_we, last.we);
                    check_vec("wb_vec", wb_vec, last.v);
                    check_lane("wb_scalar", wb_scalar, last.ro);
                end
                held    = wb_valid && !wb_ready;
                last.vd = wb_vd;
                last.we = wb_we;
                last.v  = wb_vec;
                last.ro = wb_scalar;
                if (wb_valid && wb_ready) begin
                    if (exp_q.size() == 0) begin
                        $display("Writeback seen with no instruction outstanding");
                        stop_on_error();
                    end else begin
                        exp = exp_q.pop_front();
                        check_idx("wb_vd", wb_vd, exp.vd);
                        check_bit("wb_we", wb_we, exp.we);
                        check_lane("wb_scalar", wb_scalar, exp.ro);
                        // Vector only defined for writing ops
                        if (exp.we) begin
                            check_vec("wb_vec", wb_vec, exp.v);
                            model[exp.vd]    = exp.v;
                            done_cnt[exp.vd] = done_cnt[exp.vd] + 1;
                        end
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(N_TOTAL * 3 * CLK_PERIOD * 4);
        $display("Timeout, instruction stream did not finish");
        stop_on_error();
    end

    initial begin : main
        rng          = 32'he8dc;
        rand_ready   = 1'b0;
        rst_n        = 1'b0;
        issue_valid  = 1'b0;
        issue_op     = vpu_pkg::VADD;
        issue_vd     = '0;
        issue_va     = '0;
        issue_vb     = '0;
        issue_scalar = '0;
        for (int r = 0; r < `VPU_NREGS; r++) begin
            issued_cnt[r] = 0;
        end

        // Outputs stay idle through reset
        repeat (10) begin
            @(negedge clk);
            check_bit("wb_valid", wb_valid, 1'b0);
            check_bit("issue_ready", issue_ready, 1'b1);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("wb_valid", wb_valid, 1'b0);
        check_bit("issue_ready", issue_ready, 1'b1);

        // Fill every register by splat
        for (int r = 0; r < `VPU_NREGS; r++) begin
            rng = xorshift32(rng);
            issue_one(vpu_pkg::VSPLAT, 3'(r), 3'd0, 3'd0, rng[15:0]);
        end
        drain();

        // Back-to-back single-cycle arithmetic
        repeat (N_ARITH) begin
            issue_random(1'b0);
        end
        drain();

        // Latency with an empty pipe
        timed_op(vpu_pkg::VMUL, 3);
        drain();
        timed_op(vpu_pkg::VADD, 2);
        drain();

        // Reduction leaves vd alone and a VADDS reads it back
        for (int k = 0; k < `VPU_NREGS; k++) begin
            rng = xorshift32(rng);
            issue_one(vpu_pkg::VRSUM, 3'(k), rng[2:0], 3'd0, 16'h0);
            drain();
            issue_one(vpu_pkg::VADDS, rng[5:3], 3'(k), 3'd0, 16'h0);
            drain();
        end

        // Everything under random back-pressure
        set_ready_mode(1'b1);
        repeat (N_STALL) begin
            issue_random(1'b1);
        end
        drain();
        set_ready_mode(1'b0);

        if (exp_q.size() != 0) begin
            $display("%0d results never reached writeback", exp_q.size());
            stop_on_error();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

//--- vpu_pipe.f
+incdir+rtl
rtl/vpu_pkg.sv
rtl/vpu_regfile.sv
rtl/vpu_operand_stage.sv
rtl/vpu_pipe_reg.sv
rtl/vpu_lane_alu.sv
rtl/vpu_pipe.sv
testbench/tb_vpu_pipe.sv
